// ==== board_io_pkg.sv ====
`default_nettype none

package board_io_pkg;
	// Board inputs
	localparam int N_BTN = 4;	// Push buttons
	localparam int N_SW  = 3;	// Slide switches

	// Debounce timing
	localparam int DB_CYCLES = 16;	// Cycles of disagreement before the level follows
	localparam int DB_CNT_W  = $clog2(DB_CYCLES);
	localparam logic [DB_CNT_W-1:0] DB_LAST = DB_CNT_W'(DB_CYCLES - 1);

	// Press counters and dump words
	localparam int CNT_W   = 8;	// Wrapping press count
	localparam int WORD_W  = 32;
	localparam int LVL_BIT = 8;	// Debounced level of the button
	localparam int SW_LSB  = 16;	// Synchronized switches start here
	localparam int ADDR_W  = $clog2(N_BTN);	// One word per button
	localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(N_BTN - 1);

	// Byte split of a word
	localparam int BYTE_W         = 8;
	localparam int BYTES_PER_WORD = 4;
	localparam int BYTE_IDX_W     = $clog2(BYTES_PER_WORD);
	localparam logic [BYTE_IDX_W-1:0] BYTE_LAST = BYTE_IDX_W'(BYTES_PER_WORD - 1);

	// UART framing, short bit time for simulation
	localparam int CLKS_PER_BIT = 8;
	localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
	localparam logic [CLK_CNT_W-1:0] CLK_LAST = CLK_CNT_W'(CLKS_PER_BIT - 1);
	localparam int FRAME_BITS   = BYTE_W + 2;	// Start, data and stop
	localparam int BIT_IDX_W    = $clog2(FRAME_BITS);
	localparam logic [BIT_IDX_W-1:0] BIT_LAST = BIT_IDX_W'(FRAME_BITS - 1);
endpackage

`default_nettype wire

// ==== input_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module input_sync (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic [board_io_pkg::N_BTN-1:0] btn_in,		// Raw button pins
	input  logic [board_io_pkg::N_SW-1:0]  switch_in,	// Raw switch pins
	output logic [board_io_pkg::N_BTN-1:0] btn_sync,
	output logic [board_io_pkg::N_SW-1:0]  sw_sync
);

	logic [board_io_pkg::N_BTN-1:0] btn_meta;	// First stage, may go metastable
	logic [board_io_pkg::N_SW-1:0]  sw_meta;

	// Two flops per pin
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			btn_meta <= '0;
			sw_meta  <= '0;
			btn_sync <= '0;
			sw_sync  <= '0;
		end else begin
			btn_meta <= btn_in;
			sw_meta  <= switch_in;
			btn_sync <= btn_meta;	// Settled copy
			sw_sync  <= sw_meta;
		end
	end

endmodule

`default_nettype wire

// ==== btn_debounce.sv ====
`timescale 1ns/100ps
`default_nettype none

module btn_debounce (
	input  logic CLK,
	input  logic rst_n,
	input  logic btn,		// Synchronized button
	output logic db_btn		// Debounced level
);

	// Counts consecutive cycles where btn disagrees with db_btn
	logic [board_io_pkg::DB_CNT_W-1:0] stable_cnt;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			db_btn     <= 1'b0;
			stable_cnt <= '0;
		end else if (btn != db_btn) begin
			if (stable_cnt == board_io_pkg::DB_LAST) begin
				db_btn     <= btn;	// Held long enough so follow the input
				stable_cnt <= '0;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end else begin
			stable_cnt <= '0;	// Bounce back to the old level restarts the count
		end
	end

endmodule

`default_nettype wire

// ==== press_counter_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module press_counter_bank (
	input  logic                            CLK,
	input  logic                            rst_n,
	input  logic [board_io_pkg::N_BTN-1:0]  db_btn,		// Debounced buttons
	input  logic [board_io_pkg::N_SW-1:0]   sw_sync,	// Synchronized switches
	input  logic [board_io_pkg::ADDR_W-1:0] con_addr,	// Word select, one per button
	output logic [board_io_pkg::WORD_W-1:0] con_out,	// Word at con_addr, same cycle
	output logic                            int_sig		// Interrupt line toward the core
);

	logic [board_io_pkg::N_BTN-1:0] db_prev;	// Last cycle's levels for edge detect
	logic [board_io_pkg::CNT_W-1:0] press_cnt [board_io_pkg::N_BTN];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			db_prev <= '0;
			int_sig <= 1'b0;
			for (int i = 0; i < board_io_pkg::N_BTN; i++) begin
				press_cnt[i] <= '0;
			end
		end else begin
			db_prev <= db_btn;
			int_sig <= (|db_btn) | (|sw_sync);	// Any button held or switch on
			for (int i = 0; i < board_io_pkg::N_BTN; i++) begin
				// Count rising edges only, wraps at CNT_W bits
				if (db_btn[i] && !db_prev[i]) begin
					press_cnt[i] <= press_cnt[i] + 1'b1;
				end
			end
		end
	end

	// Word layout
	// count in the low byte, level above it, switches from SW_LSB up
	always_comb begin
		con_out = '0;	// Unused bits read as zero
		con_out[board_io_pkg::CNT_W-1:0] = press_cnt[con_addr];
		con_out[board_io_pkg::LVL_BIT] = db_btn[con_addr];
		con_out[board_io_pkg::SW_LSB +: board_io_pkg::N_SW] = sw_sync;
	end

endmodule

`default_nettype wire

// ==== uart_datamemdump.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_datamemdump (
	input  logic                            CLK,
	input  logic                            rst_n,
	input  logic [board_io_pkg::WORD_W-1:0] con_out,	// Word read back at con_addr
	output logic [board_io_pkg::ADDR_W-1:0] con_addr,
	output logic [board_io_pkg::BYTE_W-1:0] byte_data,	// Byte toward the transmitter
	output logic                            byte_valid,
	input  logic                            byte_ready
);

	typedef enum logic {
		S_LOAD,		// Take a snapshot of the word at con_addr
		S_SEND		// Offer bytes until the last one is taken
	} state_t;

	state_t                              state;
	logic [board_io_pkg::WORD_W-1:0]     word_q;	// Snapshot of the current word
	logic [board_io_pkg::BYTE_IDX_W-1:0] byte_idx;	// Byte being offered, LSB first

	assign byte_valid = (state == S_SEND);
	assign byte_data  = word_q[byte_idx*board_io_pkg::BYTE_W +: board_io_pkg::BYTE_W];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_LOAD;
			byte_idx <= '0;
			con_addr <= '0;
		end else begin
			case (state)
				S_LOAD: begin
					state    <= S_SEND;
					byte_idx <= '0;
				end
				S_SEND: begin
					// Nothing moves until the transmitter takes the byte
					if (byte_ready) begin
						if (byte_idx == board_io_pkg::BYTE_LAST) begin
							state <= S_LOAD;
							// Last word wraps back to address zero
							if (con_addr == board_io_pkg::ADDR_LAST) begin
								con_addr <= '0;
							end else begin
								con_addr <= con_addr + 1'b1;
							end
						end else begin
							byte_idx <= byte_idx + 1'b1;
						end
					end
				end
				default: state <= S_LOAD;
			endcase
		end
	end

	// All bytes of one word come from this one copy
	always_ff @(posedge CLK) begin
		if (state == S_LOAD) begin
			word_q <= con_out;
		end
	end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
	input  logic                            CLK,
	input  logic                            rst_n,
	input  logic [board_io_pkg::BYTE_W-1:0] byte_data,
	input  logic                            byte_valid,
	output logic                            byte_ready,	// High only while the line is idle
	output logic                            tx		// Serial line, idles high
);

	logic                               busy;		// Frame in flight
	logic [board_io_pkg::CLK_CNT_W-1:0] clk_cnt;	// Cycles within the current bit
	logic [board_io_pkg::BIT_IDX_W-1:0] bit_idx;	// Bit of the frame on the line
	logic [board_io_pkg::FRAME_BITS-1:0] shift_q;	// Frame bits, bit 0 on the line

	assign byte_ready = !busy;
	assign tx         = shift_q[0];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			shift_q <= '1;	// Line high out of reset
		end else if (!busy) begin
			if (byte_valid) begin
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
				shift_q <= {1'b1, byte_data, 1'b0};	// Stop, data, start
			end
		end else if (clk_cnt == board_io_pkg::CLK_LAST) begin
			clk_cnt <= '0;
			shift_q <= {1'b1, shift_q[board_io_pkg::FRAME_BITS-1:1]};	// Ones fill in behind
			if (bit_idx == board_io_pkg::BIT_LAST) begin
				busy <= 1'b0;	// Stop bit done
			end else begin
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== board_io_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_io_top (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic [board_io_pkg::N_BTN-1:0] btn_in,		// Push button pins
	input  logic [board_io_pkg::N_SW-1:0]  switch_in,	// Slide switch pins
	output logic                           int_sig,		// Interrupt the core would watch
	output logic                           UART_TX
);

	logic [board_io_pkg::N_BTN-1:0]  btn_sync;
	logic [board_io_pkg::N_SW-1:0]   sw_sync;
	logic [board_io_pkg::N_BTN-1:0]  db_btn;	// One bit per debouncer
	logic [board_io_pkg::ADDR_W-1:0] con_addr;	// Dump read address
	logic [board_io_pkg::WORD_W-1:0] con_out;
	logic [board_io_pkg::BYTE_W-1:0] byte_data;
	logic                            byte_valid;
	logic                            byte_ready;

	input_sync u_sync (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.btn_in    (btn_in),
		.switch_in (switch_in),
		.btn_sync  (btn_sync),
		.sw_sync   (sw_sync)
	);

	// One debouncer per button
	for (genvar i = 0; i < board_io_pkg::N_BTN; i++) begin : g_db
		btn_debounce u_db (
			.CLK    (CLK),
			.rst_n  (rst_n),
			.btn    (btn_sync[i]),
			.db_btn (db_btn[i])
		);
	end

	// Counter bank stands in for data memory on the dump side
	press_counter_bank u_bank (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.db_btn   (db_btn),
		.sw_sync  (sw_sync),
		.con_addr (con_addr),
		.con_out  (con_out),
		.int_sig  (int_sig)
	);

	uart_datamemdump u_dump (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.con_out    (con_out),
		.con_addr   (con_addr),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready)
	);

	uart_tx u_tx (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready),
		.tx         (UART_TX)
	);

endmodule

`default_nettype wire

// ==== board_io_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_io_props (
	input logic                            CLK,
	input logic                            rst_n,
	input logic                            UART_TX,
	input logic                            byte_ready,
	input logic                            byte_valid,
	input logic [board_io_pkg::BYTE_W-1:0] byte_data,
	input logic [board_io_pkg::N_BTN-1:0]  btn_sync,
	input logic [board_io_pkg::N_BTN-1:0]  db_btn
);

	// Line idles high whenever the transmitter can take a byte
	a_idle_high: assert property (@(posedge CLK) disable iff (!rst_n)
		byte_ready |-> UART_TX)
		else $error("UART_TX low while byte_ready is high");

	// Offered byte held until it is taken
	a_byte_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		(byte_valid && !byte_ready) |=> (byte_valid && $stable(byte_data)))
		else $error("byte_valid or byte_data moved before the transfer");

	// A debounced bit only flips after the synchronized input disagreed with it
	// on every one of the DB_CYCLES cycles before the flip
	for (genvar k = 1; k <= board_io_pkg::DB_CYCLES; k++) begin : g_db_cause
		a_db_cause: assert property (@(posedge CLK) disable iff (!rst_n)
			((db_btn ^ $past(db_btn)) & ~$past(btn_sync ^ db_btn, k)) == '0)
			else $error("db_btn changed with btn_sync agreeing %0d cycles before", k);
	end

endmodule

bind board_io_top board_io_props u_props (
	.CLK        (CLK),
	.rst_n      (rst_n),
	.UART_TX    (UART_TX),
	.byte_ready (byte_ready),
	.byte_valid (byte_valid),
	.byte_data  (byte_data),
	.btn_sync   (btn_sync),
	.db_btn     (db_btn)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic rst_n
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;	// 10 ns period
	end

	// Reset held over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge CLK);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== board_io_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_io_tb;

	localparam int FRAME_CYC = 10 * board_io_pkg::CLKS_PER_BIT;	// Start, 8 data, stop
	localparam int DUMP_CYC  = board_io_pkg::N_BTN *
		(board_io_pkg::BYTES_PER_WORD * (FRAME_CYC + 1) + 1);
	localparam int HOLD_CYC  = board_io_pkg::DB_CYCLES + 8;	// Well past the debounce time
	localparam int QUIET_CYC = board_io_pkg::DB_CYCLES + 10;	// Sync, debounce, counter
	localparam int N_PHASES  = 40;
	localparam int WRAP_PRESSES = 260;	// Enough to wrap an 8-bit count
	localparam int PHASE_MAX = 3 * HOLD_CYC + 4 * board_io_pkg::DB_CYCLES + QUIET_CYC +
		2 * DUMP_CYC + 4;
	localparam int CYCLE_LIMIT = (N_PHASES + 1) * PHASE_MAX +
		WRAP_PRESSES * 2 * HOLD_CYC + 2 * DUMP_CYC;
	localparam logic [31:0] USED_BITS = 32'h0007_01FF;	// Count, level, switches

	logic                           CLK;
	logic                           rst_n;
	logic [board_io_pkg::N_BTN-1:0] btn_in;
	logic [board_io_pkg::N_SW-1:0]  switch_in;
	logic                           int_sig;
	logic                           UART_TX;

	// Reference model
	logic [board_io_pkg::CNT_W-1:0] exp_cnt [board_io_pkg::N_BTN];
	logic [board_io_pkg::N_BTN-1:0] exp_held;	// Buttons held down right now
	logic [board_io_pkg::N_SW-1:0]  exp_sw;
	logic [15:0]                    lfsr;
	bit                             settled = 1'b0;	// Inputs quiet, dump words checkable
	int                             fresh_words = 0;	// Words checked against the model
	int                             word_cnt = 0;	// Words received since reset
	int                             cycle_cnt = 0;

	tb_clock_gen u_clk (.CLK(CLK), .rst_n(rst_n));

	board_io_top DUT (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.btn_in    (btn_in),
		.switch_in (switch_in),
		.int_sig   (int_sig),
		.UART_TX   (UART_TX)
	);

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic int rand_bits(input int n);
		int v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = (v << 1) | int'(lfsr[0]);	// One step per bit
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic release_all();
		settled = 1'b0;
		btn_in <= '0;
		exp_held = '0;
		repeat (HOLD_CYC) @(posedge CLK);	// Debouncers settle low
	endtask

	// Clean press that the debouncer accepts, optionally left held
	task automatic press(input logic [board_io_pkg::ADDR_W-1:0] b, input bit keep);
		btn_in[b] <= 1'b1;
		repeat (HOLD_CYC) @(posedge CLK);
		exp_cnt[b] = exp_cnt[b] + 1'b1;	// Wraps at CNT_W bits
		exp_held[b] = 1'b1;
		if (!keep) begin
			btn_in[b] <= 1'b0;
			exp_held[b] = 1'b0;
			repeat (HOLD_CYC) @(posedge CLK);
		end
	endtask

	task automatic settle_and_check();
		int target;
		repeat (QUIET_CYC) @(posedge CLK);
		@(negedge CLK);
		check_value("int_sig", 32'(int_sig), 32'((|exp_held) | (|exp_sw)));
		@(posedge CLK);
		target = fresh_words + board_io_pkg::N_BTN;	// One full dump after the quiet
		settled = 1'b1;
		while (fresh_words < target) @(posedge CLK);
	endtask

	task automatic run_phase();
		logic [board_io_pkg::ADDR_W-1:0] b;
		logic [board_io_pkg::N_SW-1:0]   sw;
		int                              n_pulses;
		int                              action;
		release_all();
		b = board_io_pkg::ADDR_W'(rand_bits(board_io_pkg::ADDR_W));
		sw = board_io_pkg::N_SW'(rand_bits(board_io_pkg::N_SW));
		switch_in <= sw;
		exp_sw = sw;
		n_pulses = 1 + rand_bits(2);
		// Bounce pulses and gaps of 1 to 8 cycles, all shorter than DB_CYCLES
		for (int p = 0; p < n_pulses; p++) begin
			btn_in[b] <= 1'b1;
			repeat (1 + rand_bits(3)) @(posedge CLK);
			btn_in[b] <= 1'b0;
			repeat (1 + rand_bits(3)) @(posedge CLK);
		end
		action = rand_bits(2);	// 0 nothing, 1 or 2 press and release, 3 press and hold
		if (action != 0) begin
			press(b, action == 3);
		end
		settle_and_check();
	endtask

	// Timeout
	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$fatal(1, "Timeout");
		end
	end

	// UART receiver, samples mid-bit on falling edges
	initial begin : uart_rx
		logic [7:0]                      rx_byte;
		logic [31:0]                     rx_word;
		logic [31:0]                     exp_word;
		logic [31:0]                     next_word;
		logic [board_io_pkg::ADDR_W-1:0] addr;
		logic [board_io_pkg::ADDR_W-1:0] next_addr;
		bit                              fresh;
		bit                              next_fresh;
		addr = '0;
		next_fresh = 1'b0;
		next_word = '0;
		wait (rst_n === 1'b1);
		forever begin
			for (int k = 0; k < board_io_pkg::BYTES_PER_WORD; k++) begin
				@(negedge CLK);
				while (UART_TX !== 1'b0) @(negedge CLK);	// Start bit edge
				if (k == 0) begin
					fresh = next_fresh;
					exp_word = next_word;
				end
				// Next word is snapshot while the last byte of this one goes out
				if (k == board_io_pkg::BYTES_PER_WORD - 1) begin
					next_addr = (addr == board_io_pkg::ADDR_W'(board_io_pkg::N_BTN - 1)) ?
						'0 : addr + 1'b1;
					next_fresh = settled;
					next_word = '0;
					next_word[7:0] = exp_cnt[next_addr];
					next_word[8] = exp_held[next_addr];
					next_word[18:16] = exp_sw;
				end
				repeat (board_io_pkg::CLKS_PER_BIT / 2 - 1) @(negedge CLK);
				check_value("UART_TX start bit", 32'(UART_TX), 32'd0);
				repeat (8) begin
					repeat (board_io_pkg::CLKS_PER_BIT) @(negedge CLK);
					rx_byte = {UART_TX, rx_byte[7:1]};	// LSB first
				end
				repeat (board_io_pkg::CLKS_PER_BIT) @(negedge CLK);
				check_value("UART_TX stop bit", 32'(UART_TX), 32'd1);
				rx_word = {rx_byte, rx_word[31:8]};	// Low byte arrives first
			end
			if (word_cnt < board_io_pkg::N_BTN) begin
				// Word 0 may be taken before the switch synchronizer fills
				if (!(word_cnt == 0 && rx_word[18:16] == 3'b000)) begin
					check_value("switches", 32'(rx_word[18:16]), 32'(exp_sw));
				end
				check_value("press count", 32'(rx_word[7:0]), 32'd0);
				check_value("button level", 32'(rx_word[8]), 32'd0);
			end else if (fresh) begin
				check_value("press count", 32'(rx_word[7:0]), 32'(exp_word[7:0]));
				check_value("button level", 32'(rx_word[8]), 32'(exp_word[8]));
				check_value("switches", 32'(rx_word[18:16]), 32'(exp_word[18:16]));
				fresh_words++;
			end
			check_value("unused word bits", rx_word & ~USED_BITS, 32'd0);
			word_cnt++;
			addr = (addr == board_io_pkg::ADDR_W'(board_io_pkg::N_BTN - 1)) ? '0 : addr + 1'b1;
		end
	end

	initial begin
		lfsr = 16'd23;
		btn_in = '0;
		switch_in = board_io_pkg::N_SW'(rand_bits(board_io_pkg::N_SW));	// Set before reset
		exp_sw = switch_in;
		exp_held = '0;
		foreach (exp_cnt[i]) exp_cnt[i] = '0;
		wait (rst_n === 1'b1);
		while (word_cnt < board_io_pkg::N_BTN) @(posedge CLK);	// First dump
		repeat (N_PHASES) run_phase();
		// Wrap test on button 0
		release_all();
		repeat (WRAP_PRESSES) press('0, 1'b0);
		settle_and_check();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== board_io_top.f ====
board_io_pkg.sv
input_sync.sv
btn_debounce.sv
press_counter_bank.sv
uart_datamemdump.sv
uart_tx.sv
board_io_top.sv
board_io_props.sv
tb_clock_gen.sv
board_io_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= board_io_tb
FILELIST  ?= board_io_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q '\*\* PASS \*\*' $(LOG) && echo "Result: passed" || \
		(echo "Result: failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
